/* src.f */
common/cache_pkg.sv
common/way_if.sv
common/mem_if.sv
cache/cache_way.sv
cache/cache_ctrl.sv
verilog/main_mem.sv
verilog/cache_top.sv
dv/cache_checker.sv
dv/cache_tb.sv

/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing
TOP      = cache_tb
FILELIST = src.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* dv/cache_tb.sv */
// Testbench top for the two-way cache
// Clock, reset, stimulus table and the request driving loop
// Checker instance compares each response against the table

`timescale 1ns/1ns

module cache_tb;

   localparam int   TIMEOUT_CYCLES = 100;
   localparam int   NUM_ENTRIES    = 21;
   localparam logic OP_RD          = 1'b1;
   localparam logic OP_WR          = 1'b0;

   typedef struct packed {
      logic                         is_rd;
      logic [cache_pkg::ADDR_W-1:0] addr;
      cache_pkg::word_t             wdata;
      cache_pkg::word_t             exp_data;
      logic                         exp_hit;
   } entry_t;

   logic                         clk;
   logic                         rst_n;
   logic                         enable;
   logic                         rd;
   logic                         wr;
   logic [cache_pkg::ADDR_W-1:0] addr;
   cache_pkg::word_t             data_in;
   logic                         done;
   logic                         cache_hit;
   cache_pkg::word_t             data_out;

   // Expected values of the entry in flight
   logic             start;
   logic             exp_rd;
   logic             exp_hit;
   cache_pkg::word_t exp_data;
   int               test_id;
   logic             report;
   int               error_count;
   logic             timed_out;

   entry_t stim [NUM_ENTRIES];

   cache_top #(
      .MEM_LATENCY (2)
   ) dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .enable    (enable),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .done      (done),
      .cache_hit (cache_hit),
      .data_out  (data_out)
   );

   cache_checker u_chk (
      .clk         (clk),
      .rst_n       (rst_n),
      .done        (done),
      .cache_hit   (cache_hit),
      .data_out    (data_out),
      .start       (start),
      .exp_rd      (exp_rd),
      .exp_hit     (exp_hit),
      .exp_data    (exp_data),
      .test_id     (test_id),
      .report      (report),
      .error_count (error_count)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Address is {tag, index, word, 0}
   task automatic load_stimulus();
      // Write misses to line tag 1 in set 0x12 followed by a fill and a hit
      stim[0]  = '{OP_WR, 16'h0890, 16'h1111, 16'h0000, 1'b0};
      stim[1]  = '{OP_WR, 16'h0892, 16'h2222, 16'h0000, 1'b0};
      stim[2]  = '{OP_WR, 16'h0894, 16'h3333, 16'h0000, 1'b0};
      stim[3]  = '{OP_WR, 16'h0896, 16'h4444, 16'h0000, 1'b0};
      stim[4]  = '{OP_RD, 16'h0892, 16'h0000, 16'h2222, 1'b0};
      stim[5]  = '{OP_RD, 16'h0896, 16'h0000, 16'h4444, 1'b1};
      // Write hit makes way 0 dirty
      stim[6]  = '{OP_WR, 16'h0894, 16'hABCD, 16'h0000, 1'b1};
      stim[7]  = '{OP_RD, 16'h0894, 16'h0000, 16'hABCD, 1'b1};
      // Tags 2 and 3 in set 0x12 fill way 1 and then evict way 0
      stim[8]  = '{OP_WR, 16'h1090, 16'h5555, 16'h0000, 1'b0};
      stim[9]  = '{OP_WR, 16'h1890, 16'h6666, 16'h0000, 1'b0};
      stim[10] = '{OP_RD, 16'h1090, 16'h0000, 16'h5555, 1'b0};
      stim[11] = '{OP_RD, 16'h1890, 16'h0000, 16'h6666, 1'b0};
      // Victim bit now names way 1 and the written back word comes from memory
      stim[12] = '{OP_RD, 16'h0894, 16'h0000, 16'hABCD, 1'b0};
      // Read of the last word of line tag 4 in set 0x34 wraps the fill order
      stim[13] = '{OP_WR, 16'h21A0, 16'h7000, 16'h0000, 1'b0};
      stim[14] = '{OP_WR, 16'h21A2, 16'h7001, 16'h0000, 1'b0};
      stim[15] = '{OP_WR, 16'h21A4, 16'h7002, 16'h0000, 1'b0};
      stim[16] = '{OP_WR, 16'h21A6, 16'h7003, 16'h0000, 1'b0};
      stim[17] = '{OP_RD, 16'h21A6, 16'h0000, 16'h7003, 1'b0};
      stim[18] = '{OP_RD, 16'h21A0, 16'h0000, 16'h7000, 1'b1};
      stim[19] = '{OP_RD, 16'h21A2, 16'h0000, 16'h7001, 1'b1};
      stim[20] = '{OP_RD, 16'h21A4, 16'h0000, 16'h7002, 1'b1};
   endtask

   task automatic apply_entry(input int id, output logic late);
      int   waited;
      logic got_done;
      @(negedge clk);
      enable   = 1'b1;
      rd       = stim[id].is_rd;
      wr       = ~stim[id].is_rd;
      addr     = stim[id].addr;
      data_in  = stim[id].wdata;
      start    = 1'b1;
      test_id  = id;
      exp_rd   = stim[id].is_rd;
      exp_hit  = stim[id].exp_hit;
      exp_data = stim[id].exp_data;
      @(negedge clk);
      enable = 1'b0;
      rd     = 1'b0;
      wr     = 1'b0;
      start  = 1'b0;
      got_done = 1'b0;
      waited   = 0;
      while (!got_done && waited < TIMEOUT_CYCLES) begin
         @(posedge clk);
         waited++;
         got_done = done;
      end
      late = ~got_done;
      if (late) begin
         $display("test %0d: done never came within %0d cycles of the request",
                  id, TIMEOUT_CYCLES);
      end
   endtask

   initial begin
      rst_n     = 1'b0;
      enable    = 1'b0;
      rd        = 1'b0;
      wr        = 1'b0;
      addr      = '0;
      data_in   = '0;
      start     = 1'b0;
      exp_rd    = 1'b0;
      exp_hit   = 1'b0;
      exp_data  = '0;
      test_id   = 0;
      report    = 1'b0;
      timed_out = 1'b0;
      load_stimulus();
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < NUM_ENTRIES && !timed_out; i++) begin
         apply_entry(i, timed_out);
      end
      @(negedge clk);
      report = 1'b1;
      @(negedge clk);
      report = 1'b0;
      if (timed_out || error_count != 0) begin
         $display("TESTS FAILED");
      end else begin
         $display("TESTS PASSED");
      end
      $finish;
   end

endmodule

/* dv/cache_checker.sv */
// Response checker for the cache testbench
// Follows each request from its request edge to done
// Compares data, hit flag and latency, prints per-test lines and counts

`timescale 1ns/1ns

module cache_checker (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             done,
   input  logic             cache_hit,
   input  cache_pkg::word_t data_out,
   input  logic             start,
   input  logic             exp_rd,
   input  logic             exp_hit,
   input  cache_pkg::word_t exp_data,
   input  int               test_id,
   input  logic             report,
   output int               error_count
);

   logic             busy     = 1'b0;
   int               cycles   = 0;
   int               cur_id   = 0;
   logic             cur_rd   = 1'b0;
   logic             cur_hit  = 1'b0;
   cache_pkg::word_t cur_data = '0;

   int started = 0;
   int passed  = 0;
   int failed  = 0;
   int stray   = 0;

   // Unfinished requests count as errors too
   assign error_count = started - passed + stray;

   task automatic compare_result();
      int bad;
      bad = 0;
      if (cur_rd && data_out !== cur_data) begin
         $display("FAIL test %0d data_out expected 0x%h got 0x%h", cur_id, cur_data, data_out);
         bad++;
      end
      if (cache_hit !== cur_hit) begin
         $display("FAIL test %0d cache_hit expected 0x%h got 0x%h", cur_id, cur_hit, cache_hit);
         bad++;
      end
      // Hits and write misses finish in the lookup cycle
      if ((cur_hit || !cur_rd) && cycles != 1) begin
         $display("test %0d: done came %0d cycles after the request instead of 1",
                  cur_id, cycles);
         bad++;
      end
      if (bad == 0) begin
         passed++;
         $display("test %0d ok: %s hit=%0d data 0x%h after %0d cycles", cur_id,
                  cur_rd ? "read" : "write", cache_hit, data_out, cycles);
      end else begin
         failed++;
      end
   endtask

   task automatic print_summary();
      $display("tests %0d, passed %0d, failed %0d, unfinished %0d, stray done %0d",
               started, passed, failed, started - passed - failed, stray);
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         if (done) begin
            $display("done is high while reset is asserted");
            stray++;
         end
      end else begin
         if (busy) begin
            cycles++;
            if (done) begin
               compare_result();
               busy = 1'b0;
            end
         end else if (done) begin
            $display("done is high with no request pending");
            stray++;
         end
         if (start) begin
            busy     = 1'b1;
            cycles   = 0;
            cur_id   = test_id;
            cur_rd   = exp_rd;
            cur_hit  = exp_hit;
            cur_data = exp_data;
            started++;
         end
      end
      if (report) begin
         print_summary();
      end
   end

endmodule

/* verilog/cache_top.sv */
// Cache top level
// Controller, two cache ways and main memory with their buses

`timescale 1ns/1ns

module cache_top #(
   parameter int MEM_LATENCY = 2
) (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         enable,
   input  logic                         rd,
   input  logic                         wr,
   input  logic [cache_pkg::ADDR_W-1:0] addr,
   input  cache_pkg::word_t             data_in,
   output logic                         done,
   output logic                         cache_hit,
   output cache_pkg::word_t             data_out
);

   way_if way0_bus ();
   way_if way1_bus ();
   mem_if mem_bus ();

   cache_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .enable    (enable),
      .rd        (rd),
      .wr        (wr),
      .addr      (addr),
      .data_in   (data_in),
      .done      (done),
      .cache_hit (cache_hit),
      .data_out  (data_out),
      .way0      (way0_bus.ctrl),
      .way1      (way1_bus.ctrl),
      .mem       (mem_bus.ctrl)
   );

   cache_way u_way0 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way0_bus.way)
   );

   cache_way u_way1 (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way1_bus.way)
   );

   main_mem #(
      .MEM_LATENCY (MEM_LATENCY)
   ) u_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mem_bus.mem)
   );

endmodule

/* verilog/main_mem.sv */
// Main memory behind the cache
// Word array over the full byte address space
// Single-cycle writes, fixed-latency pipelined reads

`timescale 1ns/1ns

module main_mem #(
   parameter int MEM_LATENCY = 2
) (
   input  logic clk,
   input  logic rst_n,
   mem_if.mem   bus
);

   localparam int NUM_WORDS = 1 << (cache_pkg::ADDR_W - 1);

   cache_pkg::word_t mem_arr [NUM_WORDS];

   // Read pipeline with one stage per cycle of latency
   logic [MEM_LATENCY-1:0] vld_pipe;
   cache_pkg::word_t       rd_pipe [MEM_LATENCY];

   assign bus.mrvalid = vld_pipe[MEM_LATENCY-1];
   assign bus.mrdata  = rd_pipe[MEM_LATENCY-1];

   always_ff @(posedge clk) begin
      if (bus.mwr) begin
         mem_arr[bus.maddr[cache_pkg::ADDR_W-1:1]] <= bus.mwdata;
      end
      rd_pipe[0] <= mem_arr[bus.maddr[cache_pkg::ADDR_W-1:1]];
      for (int i = 1; i < MEM_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe[0] <= bus.mrd;
         for (int i = 1; i < MEM_LATENCY; i++) begin
            vld_pipe[i] <= vld_pipe[i-1];
         end
      end
   end

endmodule

/* cache/cache_ctrl.sv */
// Cache controller FSM
// Request latch, hit/miss decision and victim choice
// Dirty line writeback and wrapped-order line fill

`timescale 1ns/1ns

module cache_ctrl (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         enable,
   input  logic                         rd,
   input  logic                         wr,
   input  logic [cache_pkg::ADDR_W-1:0] addr,
   input  cache_pkg::word_t             data_in,
   output logic                         done,
   output logic                         cache_hit,
   output cache_pkg::word_t             data_out,
   way_if.ctrl                          way0,
   way_if.ctrl                          way1,
   mem_if.ctrl                          mem
);

   localparam int NUM_SETS = 1 << cache_pkg::INDEX_W;

   cache_pkg::ctrl_state_t state;
   cache_pkg::ctrl_state_t state_nxt;

   // Latched request
   logic [cache_pkg::ADDR_W-1:0] req_addr;
   cache_pkg::word_t             req_data;
   logic                         req_rd;

   cache_pkg::tag_t      req_tag;
   cache_pkg::index_t    req_index;
   cache_pkg::word_sel_t req_word;

   // Issue and return counters for writeback/fill
   cache_pkg::word_sel_t cnt;
   cache_pkg::word_sel_t ret_cnt;
   cache_pkg::word_sel_t issue_word;
   cache_pkg::word_sel_t ret_word;

   logic                victim_way;
   logic [NUM_SETS-1:0] victim_bits;

   logic hit0;
   logic hit1;
   logic pick_way;
   logic pick_dirty;
   logic fill_active;
   logic fill_last;

   assign req_tag   = req_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
   assign req_index = req_addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
   assign req_word  = req_addr[2:1];

   assign hit0 = way0.hit & way0.valid;
   assign hit1 = way1.hit & way1.valid;

   // Invalid ways are taken first and the per-set victim bit decides otherwise
   assign pick_way   = !way0.valid ? 1'b0 : (!way1.valid ? 1'b1 : victim_bits[req_index]);
   assign pick_dirty = pick_way ? (way1.valid & way1.dirty) : (way0.valid & way0.dirty);

   // Fill starts at the word after the requested one, so it returns last
   assign issue_word = req_word + cnt + 2'd1;
   assign ret_word   = req_word + ret_cnt + 2'd1;

   assign fill_active = (state == cache_pkg::FILL_ISSUE) || (state == cache_pkg::FILL_WAIT);
   assign fill_last   = fill_active && mem.mrvalid && (ret_cnt == 2'd3);

   always_comb begin
      state_nxt = state;
      case (state)
         cache_pkg::IDLE: begin
            if (enable && (rd || wr)) begin
               state_nxt = cache_pkg::LOOKUP;
            end
         end
         cache_pkg::LOOKUP: begin
            if (hit0 || hit1 || !req_rd) begin
               state_nxt = cache_pkg::IDLE;
            end else if (pick_dirty) begin
               state_nxt = cache_pkg::WRITEBACK;
            end else begin
               state_nxt = cache_pkg::FILL_ISSUE;
            end
         end
         cache_pkg::WRITEBACK: begin
            if (cnt == 2'd3) begin
               state_nxt = cache_pkg::FILL_ISSUE;
            end
         end
         cache_pkg::FILL_ISSUE: begin
            if (cnt == 2'd3) begin
               state_nxt = cache_pkg::FILL_WAIT;
            end
         end
         cache_pkg::FILL_WAIT: begin
            if (fill_last) begin
               state_nxt = cache_pkg::IDLE;
            end
         end
         default: state_nxt = cache_pkg::IDLE;
      endcase
   end

   always_comb begin
      done      = 1'b0;
      cache_hit = 1'b0;
      data_out  = '0;

      way0.index       = req_index;
      way0.word_sel    = req_word;
      way0.tag_in      = req_tag;
      way0.wdata       = req_data;
      way0.wr_word     = 1'b0;
      way0.fill        = 1'b0;
      way0.set_dirty   = 1'b0;
      way0.clear_dirty = 1'b0;

      way1.index       = req_index;
      way1.word_sel    = req_word;
      way1.tag_in      = req_tag;
      way1.wdata       = req_data;
      way1.wr_word     = 1'b0;
      way1.fill        = 1'b0;
      way1.set_dirty   = 1'b0;
      way1.clear_dirty = 1'b0;

      mem.maddr  = '0;
      mem.mwdata = '0;
      mem.mwr    = 1'b0;
      mem.mrd    = 1'b0;

      case (state)
         cache_pkg::LOOKUP: begin
            if (hit0 || hit1) begin
               done      = 1'b1;
               cache_hit = 1'b1;
               if (req_rd) begin
                  data_out = hit0 ? way0.rdata : way1.rdata;
               end else begin
                  way0.wr_word   = hit0;
                  way0.set_dirty = hit0;
                  way1.wr_word   = hit1 & ~hit0;
                  way1.set_dirty = hit1 & ~hit0;
               end
            end else if (!req_rd) begin
               // Write miss goes straight to memory without allocating a line
               done       = 1'b1;
               mem.maddr  = req_addr;
               mem.mwdata = req_data;
               mem.mwr    = 1'b1;
            end
         end
         cache_pkg::WRITEBACK: begin
            way0.word_sel = cnt;
            way1.word_sel = cnt;
            mem.maddr  = {victim_way ? way1.tag_out : way0.tag_out, req_index, cnt, 1'b0};
            mem.mwdata = victim_way ? way1.rdata : way0.rdata;
            mem.mwr    = 1'b1;
         end
         cache_pkg::FILL_ISSUE: begin
            mem.maddr = {req_tag, req_index, issue_word, 1'b0};
            mem.mrd   = 1'b1;
         end
         default: ;
      endcase

      // Returned words may arrive while reads are still being issued
      if (fill_active && mem.mrvalid) begin
         way0.word_sel = ret_word;
         way1.word_sel = ret_word;
         way0.wdata    = mem.mrdata;
         way1.wdata    = mem.mrdata;
         way0.wr_word  = ~victim_way;
         way1.wr_word  = victim_way;
         if (fill_last) begin
            way0.fill        = ~victim_way;
            way0.clear_dirty = ~victim_way;
            way1.fill        = victim_way;
            way1.clear_dirty = victim_way;
            done             = 1'b1;
            data_out         = mem.mrdata;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= cache_pkg::IDLE;
         cnt         <= '0;
         ret_cnt     <= '0;
         victim_way  <= 1'b0;
         victim_bits <= '0;
      end else begin
         state <= state_nxt;
         case (state)
            cache_pkg::LOOKUP: begin
               cnt        <= '0;
               ret_cnt    <= '0;
               victim_way <= pick_way;
            end
            cache_pkg::WRITEBACK,
            cache_pkg::FILL_ISSUE: cnt <= cnt + 2'd1;
            default: ;
         endcase
         if (fill_active && mem.mrvalid) begin
            ret_cnt <= ret_cnt + 2'd1;
         end
         if (fill_last) begin
            victim_bits[req_index] <= ~victim_bits[req_index];
         end
      end
   end

   // Request is only taken while idle
   always_ff @(posedge clk) begin
      if (state == cache_pkg::IDLE && enable && (rd || wr)) begin
         req_addr <= addr;
         req_data <= data_in;
         req_rd   <= rd;
      end
   end

endmodule

/* cache/cache_way.sv */
// One cache way
// Tag, valid, dirty and line data storage per set
// Combinational read and tag compare, registered writes

`timescale 1ns/1ns

module cache_way (
   input  logic clk,
   input  logic rst_n,
   way_if.way   bus
);

   localparam int NUM_SETS = 1 << cache_pkg::INDEX_W;

   cache_pkg::tag_t  tag_mem  [NUM_SETS];
   cache_pkg::word_t data_mem [NUM_SETS][cache_pkg::WORDS_PER_LINE];

   logic [NUM_SETS-1:0] valid_bits;
   logic [NUM_SETS-1:0] dirty_bits;

   assign bus.valid   = valid_bits[bus.index];
   assign bus.dirty   = dirty_bits[bus.index];
   assign bus.tag_out = tag_mem[bus.index];
   assign bus.rdata   = data_mem[bus.index][bus.word_sel];

   // Raw tag match that the controller qualifies with valid
   assign bus.hit = (tag_mem[bus.index] == bus.tag_in);

   always_ff @(posedge clk) begin
      if (bus.wr_word) begin
         data_mem[bus.index][bus.word_sel] <= bus.wdata;
      end
      if (bus.fill) begin
         tag_mem[bus.index] <= bus.tag_in;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else begin
         if (bus.fill) begin
            valid_bits[bus.index] <= 1'b1;
         end
         if (bus.clear_dirty) begin
            dirty_bits[bus.index] <= 1'b0;
         end else if (bus.set_dirty) begin
            dirty_bits[bus.index] <= 1'b1;
         end
      end
   end

endmodule

/* common/mem_if.sv */
// Bus between the cache controller and main memory
// Word write and pipelined read commands with read return

`timescale 1ns/1ns

interface mem_if;

   logic [cache_pkg::ADDR_W-1:0] maddr;
   cache_pkg::word_t             mwdata;
   logic                         mwr;
   logic                         mrd;

   // Read return, in issue order
   cache_pkg::word_t             mrdata;
   logic                         mrvalid;

   modport ctrl (
      output maddr, mwdata, mwr, mrd,
      input  mrdata, mrvalid
   );

   modport mem (
      input  maddr, mwdata, mwr, mrd,
      output mrdata, mrvalid
   );

endinterface

/* common/way_if.sv */
// Bus between the cache controller and one cache way
// Lookup address, write strobes and returned tag/status/data

`timescale 1ns/1ns

interface way_if;

   // Controller to way
   cache_pkg::index_t    index;
   cache_pkg::word_sel_t word_sel;
   cache_pkg::tag_t      tag_in;
   cache_pkg::word_t     wdata;
   logic                 wr_word;
   logic                 fill;
   logic                 set_dirty;
   logic                 clear_dirty;

   // Way to controller
   logic                 hit;
   logic                 valid;
   logic                 dirty;
   cache_pkg::tag_t      tag_out;
   cache_pkg::word_t     rdata;

   modport ctrl (
      output index, word_sel, tag_in, wdata, wr_word, fill, set_dirty, clear_dirty,
      input  hit, valid, dirty, tag_out, rdata
   );

   modport way (
      input  index, word_sel, tag_in, wdata, wr_word, fill, set_dirty, clear_dirty,
      output hit, valid, dirty, tag_out, rdata
   );

endinterface

/* common/cache_pkg.sv */
// Shared definitions for the two-way set-associative cache
// Address field widths, data width and line geometry
// Word, tag, index and word-select types
// Controller state encoding

package cache_pkg;

   // Byte address and data word widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;

   // Address split into tag, index and byte offset
   localparam int TAG_W    = 5;
   localparam int INDEX_W  = 8;
   localparam int OFFSET_W = 3;

   // Four 16-bit words per line
   localparam int WORDS_PER_LINE = 4;

   typedef logic [DATA_W-1:0]  word_t;
   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

   // Controller states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WRITEBACK,
      FILL_ISSUE,
      FILL_WAIT
   } ctrl_state_t;

endpackage
